// File: Makefile
TOP := tb_samcoupe_asic

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: filelist.f
logic/asic_pkg.sv
logic/port_decoder.sv
logic/memory_pager.sv
logic/border_sound.sv
logic/midi_tx_timer.sv
logic/samcoupe_asic.sv
testbench/tb_samcoupe_asic.sv

// File: logic/asic_pkg.sv
//====================
// SAM Coupe ASIC package
// Port numbers, widths and the shared bus, paging and memory-map types
//====================

`default_nettype none

package asic_pkg;

	// ==================== I/O ports (low address byte)
	localparam logic [7:0] PORT_EXT_C    = 8'h80;  // External RAM page, section C
	localparam logic [7:0] PORT_EXT_D    = 8'h81;  // External RAM page, section D
	localparam logic [7:0] PORT_LPT_DATA = 8'hE8;
	localparam logic [7:0] PORT_LPT_STB  = 8'hE9;
	localparam logic [7:0] PORT_STATUS   = 8'hF9;
	localparam logic [7:0] PORT_LMPR     = 8'hFA;
	localparam logic [7:0] PORT_HMPR     = 8'hFB;
	localparam logic [7:0] PORT_MIDI     = 8'hFD;
	localparam logic [7:0] PORT_BORDER   = 8'hFE;

	// ==================== Memory map
	localparam int MEM_AW = 23;
	localparam int PAGE_W = 5;
	localparam int SECT_W = 14;  // 16 KB sections
	localparam logic [MEM_AW-SECT_W-1:0] EXT_BASE = 9'h040;
	localparam logic [MEM_AW-1:0] ROM_BASE = 23'h08_0000;

	// ==================== Sound and MIDI
	localparam int AUDIO_W     = 18;
	localparam int MIDI_FRAME  = 319;  // In 1 MHz ticks
	localparam int MIDI_INT_AT = 15;
	localparam int CE_1M_DIV   = 96;
	localparam int CE_DIV_W    = $clog2(CE_1M_DIV);
	localparam int MIDI_CNT_W  = $clog2(MIDI_FRAME + 1);

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        io_wr;  // Level, whole I/O write cycle
		logic        io_rd;
	} cpu_bus_t;

	// One-cycle write strobes, data stays on the CPU bus
	typedef struct packed {
		logic wr_edge;  // Any port write, first cycle
		logic ext_c;
		logic ext_d;
		logic lpt_data;
		logic lpt_stb;
		logic lmpr;
		logic hmpr;
		logic midi;
		logic border;
	} port_wr_t;

	typedef struct packed {
		logic              wp_or_ext;  // LMPR write protect, HMPR ext RAM
		logic [1:0]        rom_ctl;
		logic [PAGE_W-1:0] page;
	} page_fields_t;

	typedef union packed {
		logic [7:0]   raw;
		page_fields_t f;
	} page_reg_u;

	typedef struct packed {
		logic [MEM_AW-1:0] ram_addr;
		logic              is_rom;
		logic              writable;
		logic              present;
	} mem_map_t;

endpackage

`default_nettype wire

// File: logic/border_sound.sv
//====================
// Border and sound
// Border colour and EAR bit, printer port sample DAC,
// mixed into left and right audio levels
//====================

`default_nettype none

module border_sound (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire asic_pkg::cpu_bus_t      cpu_bus,
	input  wire asic_pkg::port_wr_t      port_wr,
	output logic [3:0]                   border_color,
	output logic                         ear,
	output logic [asic_pkg::AUDIO_W-1:0] audio_l,
	output logic [asic_pkg::AUDIO_W-1:0] audio_r
);

	import asic_pkg::*;

	logic [7:0] lpt_data;  // Sample waiting for a strobe edge
	logic [7:0] vox_l;
	logic [7:0] vox_r;
	logic       stb_q;     // Last strobe bit 0

	// Voice at two weights plus the EAR bit
	function automatic logic [AUDIO_W-1:0] mix_level(input logic [7:0] voice,
		input logic ear_bit);
		logic [AUDIO_W-1:0] v;
		v = AUDIO_W'(voice);
		mix_level = (v << 2) + (v << 10) + (AUDIO_W'(ear_bit) << 15);
	endfunction

	// ==================== Border port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear          <= 1'b0;
		end else if (port_wr.border) begin
			border_color <= {cpu_bus.dout[5], cpu_bus.dout[2:0]};
			ear          <= cpu_bus.dout[4];
		end
	end

	// ==================== Printer port DAC
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lpt_data <= '0;
		end else if (port_wr.lpt_data) begin
			lpt_data <= cpu_bus.dout;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l <= '0;
			vox_r <= '0;
			stb_q <= 1'b0;
		end else if (port_wr.lpt_stb) begin
			if (~stb_q & cpu_bus.dout[0]) vox_l <= lpt_data;  // Rising edge
			if (stb_q & ~cpu_bus.dout[0]) vox_r <= lpt_data;  // Falling edge
			stb_q <= cpu_bus.dout[0];
		end
	end

	assign audio_l = mix_level(vox_l, ear);
	assign audio_r = mix_level(vox_r, ear);

endmodule

`default_nettype wire

// File: logic/memory_pager.sv
//====================
// Memory pager
// LMPR, HMPR and external RAM page registers,
// CPU address to RAM or ROM byte address
//====================

`default_nettype none

module memory_pager (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire asic_pkg::cpu_bus_t cpu_bus,
	input  wire asic_pkg::port_wr_t port_wr,
	input  wire                 ext_ram_off,
	output asic_pkg::page_reg_u lmpr,
	output asic_pkg::page_reg_u hmpr,
	output asic_pkg::mem_map_t  mem_map
);

	import asic_pkg::*;

	logic [7:0] ext_c;
	logic [7:0] ext_d;
	logic       ext_dis;  // External RAM switched off

	logic [1:0]                 section;
	logic [SECT_W-1:0]          offset;
	logic [PAGE_W-1:0]          page_b;
	logic [PAGE_W-1:0]          page_d;
	logic [MEM_AW-SECT_W-1:0]   page;
	logic [MEM_AW-1:0]          rom_addr;
	logic                       rom0_sel;
	logic                       rom1_sel;
	logic                       ext_sel;
	logic                       wp_sel;

	// ==================== Page registers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= '0;
			hmpr    <= '0;
			ext_c   <= '0;
			ext_d   <= '0;
			ext_dis <= ext_ram_off;  // Sampled for as long as reset is held
		end else begin
			if (port_wr.lmpr)  lmpr.raw <= cpu_bus.dout;
			if (port_wr.hmpr)  hmpr.raw <= cpu_bus.dout;
			if (port_wr.ext_c) ext_c    <= cpu_bus.dout;
			if (port_wr.ext_d) ext_d    <= cpu_bus.dout;
		end
	end

	// ==================== Address translation
	assign section = cpu_bus.addr[15:14];
	assign offset  = cpu_bus.addr[SECT_W-1:0];

	assign rom0_sel = ~lmpr.f.rom_ctl[0] & (section == 2'd0);
	assign rom1_sel =  lmpr.f.rom_ctl[1] & (section == 2'd3);
	assign ext_sel  =  hmpr.f.wp_or_ext & cpu_bus.addr[15];
	assign wp_sel   =  lmpr.f.wp_or_ext & (section == 2'd0);

	// Odd sections follow their pair, wrapping in 32 pages
	assign page_b = lmpr.f.page + 1'b1;
	assign page_d = hmpr.f.page + 1'b1;

	// ROM0 low 16 KB, ROM1 32 KB further up
	assign rom_addr = ROM_BASE + MEM_AW'({cpu_bus.addr[15], 1'b0, offset});

	always_comb begin
		if (ext_sel) begin
			page = EXT_BASE + {1'b0, (section[0] ? ext_d : ext_c)};
		end else begin
			case (section)
				2'd0:    page = {4'b0000, lmpr.f.page};
				2'd1:    page = {4'b0000, page_b};
				2'd2:    page = {4'b0000, hmpr.f.page};
				default: page = {4'b0000, page_d};
			endcase
		end
	end

	always_comb begin
		mem_map.is_rom   = rom0_sel | rom1_sel;
		mem_map.present  = ~(ext_sel & ext_dis) | mem_map.is_rom;
		mem_map.writable = ~mem_map.is_rom & ~wp_sel & mem_map.present;
		mem_map.ram_addr = mem_map.is_rom ? rom_addr : {page, offset};
	end

	a_rom_read_only: assert property (@(posedge clk_sys) disable iff (reset)
		mem_map.is_rom |-> !mem_map.writable);

endmodule

`default_nettype wire

// File: logic/midi_tx_timer.sv
//====================
// MIDI transmit timer
// 1 MHz tick, transmit frame and MIDI interrupt
//====================

`default_nettype none

module midi_tx_timer (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire asic_pkg::port_wr_t port_wr,
	output logic                    midi_tx,
	output logic                    midi_int
);

	import asic_pkg::*;

	logic [CE_DIV_W-1:0]   div_cnt;
	logic                  ce_1m;
	logic                  pending;  // Byte written, frame not started
	logic [MIDI_CNT_W-1:0] tx_time;

	// ==================== 1 MHz enable
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			ce_1m   <= 1'b0;
		end else begin
			if (div_cnt == CE_DIV_W'(CE_1M_DIV - 1)) div_cnt <= '0;
			else div_cnt <= div_cnt + 1'b1;
			ce_1m <= (div_cnt == '0);
		end
	end

	// ==================== Transmit frame
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending  <= 1'b0;
			tx_time  <= '0;
			midi_tx  <= 1'b0;
			midi_int <= 1'b0;
		end else begin
			if (ce_1m) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					if (tx_time == MIDI_CNT_W'(MIDI_INT_AT)) midi_int <= 1'b1;
				end else begin
					midi_tx  <= 1'b0;  // Frame over
					midi_int <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						tx_time <= MIDI_CNT_W'(MIDI_FRAME);
						pending <= 1'b0;
					end
				end
			end
			if (port_wr.midi) pending <= 1'b1;  // Wins over a same-cycle start
		end
	end

	a_int_in_frame: assert property (@(posedge clk_sys) disable iff (reset)
		midi_int |-> midi_tx);

endmodule

`default_nettype wire

// File: logic/port_decoder.sv
//====================
// Port decoder
// Edge-detects CPU port writes into one-cycle strobes
// and builds the ASIC readback byte
//====================

`default_nettype none

module port_decoder (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire asic_pkg::cpu_bus_t  cpu_bus,
	input  wire asic_pkg::page_reg_u lmpr,
	input  wire asic_pkg::page_reg_u hmpr,
	input  wire                  midi_int,
	output asic_pkg::port_wr_t   port_wr,
	output logic [7:0]           asic_dout
);

	import asic_pkg::*;

	logic       io_wr_q;  // io_wr one cycle ago
	logic       wr_edge;
	logic [7:0] port;

	assign port = cpu_bus.addr[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= cpu_bus.io_wr;
		end
	end

	// Only the first cycle of a write cycle counts
	assign wr_edge = cpu_bus.io_wr & ~io_wr_q;

	// ==================== Write strobes
	always_comb begin
		port_wr          = '0;
		port_wr.wr_edge  = wr_edge;
		port_wr.ext_c    = wr_edge & (port == PORT_EXT_C);
		port_wr.ext_d    = wr_edge & (port == PORT_EXT_D);
		port_wr.lpt_data = wr_edge & (port == PORT_LPT_DATA);
		port_wr.lpt_stb  = wr_edge & (port == PORT_LPT_STB);
		port_wr.lmpr     = wr_edge & (port == PORT_LMPR);
		port_wr.hmpr     = wr_edge & (port == PORT_HMPR);
		port_wr.midi     = wr_edge & (port == PORT_MIDI);
		port_wr.border   = wr_edge & (port == PORT_BORDER);
	end

	// ==================== Readback
	always_comb begin
		asic_dout = 8'hFF;  // Idle bus
		if (cpu_bus.io_rd) begin
			case (port)
				PORT_LMPR:   asic_dout = lmpr.raw;
				PORT_HMPR:   asic_dout = hmpr.raw;
				// Line, frame and keyboard bits held inactive
				PORT_STATUS: asic_dout = {3'b111, ~midi_int, 4'b1111};
				PORT_LPT_DATA,
				PORT_LPT_STB: asic_dout = 8'h00;  // Dummy printer port
				default:     asic_dout = 8'hFF;
			endcase
		end
	end

	// At most one decoded register per write
	a_single_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		port_wr.wr_edge |->
			$onehot0({port_wr.ext_c, port_wr.ext_d, port_wr.lpt_data,
				port_wr.lpt_stb, port_wr.lmpr, port_wr.hmpr, port_wr.midi}));

endmodule

`default_nettype wire

// File: logic/samcoupe_asic.sv
//====================
// SAM Coupe ASIC top
// Port decode, paging, border and sound, MIDI timer
//====================

`default_nettype none

module samcoupe_asic (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire asic_pkg::cpu_bus_t      cpu_bus,
	input  wire                          ext_ram_off,
	output asic_pkg::mem_map_t           mem_map,
	output logic [7:0]                   asic_dout,
	output logic [3:0]                   border_color,
	output logic                         ear,
	output logic [asic_pkg::AUDIO_W-1:0] audio_l,
	output logic [asic_pkg::AUDIO_W-1:0] audio_r,
	output logic                         midi_tx,
	output logic                         midi_int
);

	import asic_pkg::*;

	port_wr_t  port_wr;
	page_reg_u lmpr;
	page_reg_u hmpr;

	port_decoder u_port_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_bus   (cpu_bus),
		.lmpr      (lmpr),
		.hmpr      (hmpr),
		.midi_int  (midi_int),
		.port_wr   (port_wr),
		.asic_dout (asic_dout)
	);

	memory_pager u_memory_pager (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_bus     (cpu_bus),
		.port_wr     (port_wr),
		.ext_ram_off (ext_ram_off),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.mem_map     (mem_map)
	);

	border_sound u_border_sound (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_bus      (cpu_bus),
		.port_wr      (port_wr),
		.border_color (border_color),
		.ear          (ear),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	midi_tx_timer u_midi_tx_timer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.port_wr  (port_wr),
		.midi_tx  (midi_tx),
		.midi_int (midi_int)
	);

endmodule

`default_nettype wire

// File: testbench/tb_samcoupe_asic.sv
//====================
// SAM Coupe ASIC testbench
// Directed tests of port decode, paging, border and sound, MIDI timer
//====================

`default_nettype none

module tb_samcoupe_asic;

	import asic_pkg::*;

	logic                 clk_sys;
	logic                 reset;
	cpu_bus_t             cpu_bus;
	logic                 ext_ram_off;
	mem_map_t             mem_map;
	logic [7:0]           asic_dout;
	logic [3:0]           border_color;
	logic                 ear;
	logic [AUDIO_W-1:0]   audio_l;
	logic [AUDIO_W-1:0]   audio_r;
	logic                 midi_tx;
	logic                 midi_int;

	integer seed = 32'h9129_6167;

	// Expected register state, kept by the tests
	logic [7:0] lmpr_m, hmpr_m, extc_m, extd_m;
	logic       extdis_m;
	logic [7:0] vox_l_m, vox_r_m;
	logic       ear_m;

	samcoupe_asic DUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_bus      (cpu_bus),
		.ext_ram_off  (ext_ram_off),
		.mem_map      (mem_map),
		.asic_dout    (asic_dout),
		.border_color (border_color),
		.ear          (ear),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.midi_tx      (midi_tx),
		.midi_int     (midi_int)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==================== Watchdog
	initial begin
		repeat (2000 * CE_1M_DIV) @(posedge clk_sys);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Test failures found");
		$fatal(1, "watchdog");
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "check failed");
		end
	endtask

	task automatic step();  // Drive point, just after the rising edge
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset(input logic ext_off);
		step();
		ext_ram_off = ext_off;
		reset       = 1'b1;
		repeat (2) step();
		reset    = 1'b0;
		lmpr_m   = '0;
		hmpr_m   = '0;
		extc_m   = '0;
		extd_m   = '0;
		extdis_m = ext_off;
		vox_l_m  = '0;
		vox_r_m  = '0;
		ear_m    = 1'b0;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		step();
		cpu_bus.addr  = {8'h12, port};  // High byte is not decoded
		cpu_bus.dout  = data;
		cpu_bus.io_wr = 1'b1;
		repeat (2) step();
		cpu_bus.io_wr = 1'b0;
		step();
	endtask

	task automatic check_read(input logic [7:0] port, input logic [7:0] expected);
		step();
		cpu_bus.addr  = {8'h12, port};
		cpu_bus.io_rd = 1'b1;
		@(negedge clk_sys);
		check_value(32'(asic_dout), 32'(expected), $sformatf("read of port %h", port));
		step();
		cpu_bus.io_rd = 1'b0;
	endtask

	// Memory map from the paging rules and the expected registers
	function automatic mem_map_t expected_map(input logic [15:0] a);
		mem_map_t   m;
		logic [1:0] sect;
		logic [8:0] pg;
		logic       rom;
		logic       ext;
		sect = a[15:14];
		rom  = (sect == 2'd0 && !lmpr_m[5]) || (sect == 2'd3 && lmpr_m[6]);
		ext  = hmpr_m[7] && a[15];
		case (sect)
			2'd0:    pg = {4'd0, lmpr_m[4:0]};
			2'd1:    pg = {4'd0, lmpr_m[4:0] + 5'd1};
			2'd2:    pg = {4'd0, hmpr_m[4:0]};
			default: pg = {4'd0, hmpr_m[4:0] + 5'd1};
		endcase
		if (ext) pg = EXT_BASE + {1'b0, (sect == 2'd3) ? extd_m : extc_m};
		if (rom) m.ram_addr = ROM_BASE + {7'd0, a[15], 1'b0, a[13:0]};
		else m.ram_addr = {pg, a[13:0]};
		m.is_rom   = rom;
		m.present  = rom || !(ext && extdis_m);
		m.writable = !rom && !(sect == 2'd0 && lmpr_m[7]) && m.present;
		return m;
	endfunction

	task automatic check_map(input logic [15:0] a);
		mem_map_t exp;
		step();
		cpu_bus.addr = a;
		@(negedge clk_sys);
		exp = expected_map(a);
		check_value(32'(mem_map.ram_addr), 32'(exp.ram_addr), $sformatf("ram_addr @%h", a));
		check_value(32'(mem_map.is_rom), 32'(exp.is_rom), $sformatf("is_rom @%h", a));
		check_value(32'(mem_map.writable), 32'(exp.writable), $sformatf("writable @%h", a));
		check_value(32'(mem_map.present), 32'(exp.present), $sformatf("present @%h", a));
	endtask

	function automatic logic [15:0] random_addr(input logic [1:0] sect);
		logic [15:0] r;
		r = 16'($random(seed));
		return {sect, r[13:0]};
	endfunction

	function automatic logic [AUDIO_W-1:0] expected_level(input logic [7:0] v, input logic e);
		int lvl;
		lvl = int'(v) * 4 + int'(v) * 1024 + (e ? 32768 : 0);
		return AUDIO_W'(lvl);
	endfunction

	task automatic check_audio();
		@(negedge clk_sys);
		check_value(32'(audio_l), 32'(expected_level(vox_l_m, ear_m)), "audio_l");
		check_value(32'(audio_r), 32'(expected_level(vox_r_m, ear_m)), "audio_r");
	endtask

	task automatic wait_midi(input logic use_int, input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (((use_int ? midi_int : midi_tx) !== level) && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if ((use_int ? midi_int : midi_tx) !== level) begin
			$display("MIDI %s did not go to %b within %0d clocks", use_int ? "int" : "tx",
				level, limit);
			$display("Test failures found");
			$fatal(1, "MIDI wait timed out");
		end
	endtask

	// ==================== Tests
	task automatic test_reset_state();
		@(negedge clk_sys);
		check_value(32'(border_color), 32'd0, "border after reset");
		check_value(32'(ear), 32'd0, "ear after reset");
		check_value(32'(midi_tx), 32'd0, "midi_tx after reset");
		check_value(32'(midi_int), 32'd0, "midi_int after reset");
		check_audio();
		check_read(PORT_LMPR, 8'h00);
		check_read(PORT_HMPR, 8'h00);
		check_read(PORT_STATUS, {3'b111, 1'b1, 4'b1111});
		check_read(PORT_LPT_DATA, 8'h00);
		check_read(8'h3C, 8'hFF);  // Unused port
	endtask

	task automatic test_paging();
		lmpr_m = 8'($random(seed)) & 8'h1F;
		hmpr_m = 8'($random(seed)) & 8'h1F;
		io_write(PORT_LMPR, lmpr_m);
		io_write(PORT_HMPR, hmpr_m);
		check_read(PORT_LMPR, lmpr_m);
		check_read(PORT_HMPR, hmpr_m);
		for (int s = 0; s < 4; s++) check_map(random_addr(2'(s)));
		lmpr_m = 8'h20 | (8'($random(seed)) & 8'h1F);  // ROM0 off, RAM in section A
		io_write(PORT_LMPR, lmpr_m);
		for (int s = 0; s < 4; s++) check_map(random_addr(2'(s)));
		// Long write cycle, data changes while io_wr stays high
		step();
		cpu_bus.addr  = {8'h12, PORT_LMPR};
		cpu_bus.dout  = 8'h2B;
		cpu_bus.io_wr = 1'b1;
		step();
		cpu_bus.dout = 8'h35;
		repeat (3) step();
		cpu_bus.io_wr = 1'b0;
		lmpr_m = 8'h2B;
		check_read(PORT_LMPR, lmpr_m);
	endtask

	task automatic test_rom_wp();
		lmpr_m = 8'h40 | (lmpr_m & 8'h1F);  // ROM0 and ROM1 both in
		io_write(PORT_LMPR, lmpr_m);
		check_map(16'h0123);
		check_value(32'(mem_map.is_rom), 32'd1, "ROM0 select");
		check_value(32'(mem_map.writable), 32'd0, "ROM0 writable");
		check_map(16'hF456);
		check_value(32'(mem_map.is_rom), 32'd1, "ROM1 select");
		check_value(32'(mem_map.writable), 32'd0, "ROM1 writable");
		check_map(random_addr(2'd1));
		check_map(random_addr(2'd2));
		lmpr_m = 8'hA0 | (lmpr_m & 8'h1F);  // Section A protected
		io_write(PORT_LMPR, lmpr_m);
		check_map(random_addr(2'd0));
		check_value(32'(mem_map.writable), 32'd0, "protected section A");
		check_map(random_addr(2'd1));
		check_value(32'(mem_map.writable), 32'd1, "section B");
	endtask

	task automatic test_ext_ram();
		for (int pass = 0; pass < 2; pass++) begin
			apply_reset(pass == 1);
			extc_m = 8'($random(seed));
			extd_m = 8'($random(seed));
			hmpr_m = 8'h80 | (8'($random(seed)) & 8'h1F);
			io_write(PORT_EXT_C, extc_m);
			io_write(PORT_EXT_D, extd_m);
			io_write(PORT_HMPR, hmpr_m);
			check_map(random_addr(2'd1));
			check_map(random_addr(2'd2));
			check_value(32'(mem_map.present), (pass == 1) ? 32'd0 : 32'd1, "ext C present");
			check_map(random_addr(2'd3));
			check_value(32'(mem_map.writable), (pass == 1) ? 32'd0 : 32'd1, "ext D writable");
		end
		apply_reset(1'b0);
	endtask

	task automatic test_border_sound();
		logic [7:0] smp;
		io_write(PORT_BORDER, 8'h3D);
		ear_m = 1'b1;
		@(negedge clk_sys);
		check_value(32'(border_color), 32'hD, "border colour");
		check_value(32'(ear), 32'd1, "ear");
		smp = 8'($random(seed));
		io_write(PORT_LPT_DATA, smp);
		io_write(PORT_LPT_STB, 8'h01);  // Rising strobe, left voice
		vox_l_m = smp;
		check_audio();
		smp = 8'($random(seed));
		io_write(PORT_LPT_DATA, smp);
		io_write(PORT_LPT_STB, 8'h00);  // Falling strobe, right voice
		vox_r_m = smp;
		check_audio();
		io_write(PORT_LPT_DATA, 8'hA5);
		io_write(PORT_LPT_STB, 8'h00);  // No edge, nothing loads
		check_audio();
		io_write(PORT_LPT_STB, 8'h01);
		vox_l_m = 8'hA5;
		io_write(PORT_BORDER, 8'h00);
		ear_m = 1'b0;
		check_audio();
	endtask

	task automatic test_midi();
		check_read(PORT_STATUS, 8'hFF);
		io_write(PORT_MIDI, 8'h90);
		wait_midi(1'b0, 1'b1, 3 * CE_1M_DIV);
		wait_midi(1'b1, 1'b1, (MIDI_FRAME + 2) * CE_1M_DIV);
		check_value(32'(midi_tx), 32'd1, "midi_tx during interrupt");
		check_read(PORT_STATUS, {3'b111, 1'b0, 4'b1111});
		wait_midi(1'b0, 1'b0, (MIDI_INT_AT + 2) * CE_1M_DIV);
		check_value(32'(midi_int), 32'd0, "midi_int at frame end");
		repeat (4 * CE_1M_DIV) begin
			@(negedge clk_sys);
			check_value(32'(midi_tx), 32'd0, "midi_tx without a new write");
		end
		io_write(PORT_MIDI, 8'h45);
		wait_midi(1'b0, 1'b1, 3 * CE_1M_DIV);
		wait_midi(1'b0, 1'b0, (MIDI_FRAME + 2) * CE_1M_DIV);
		check_value(32'(midi_int), 32'd0, "midi_int after second frame");
	endtask

	initial begin
		reset       = 1'b1;
		ext_ram_off = 1'b0;
		cpu_bus     = '0;
		apply_reset(1'b0);
		test_reset_state();
		test_paging();
		test_rom_wp();
		test_ext_ram();
		test_border_sound();
		test_midi();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
